/* hdl/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath width for instructions, addresses and data
`define WORD_SIZE 16

// instruction queue entries and the starting credit count
`define QUEUE_DEPTH 4

`define NUM_REGS 4

// r-type function codes outside the alu group
`define FUNC_WWD 6'd28
`define FUNC_HLT 6'd29

`endif

/* hdl/isa_pkg.sv */
`default_nettype none

`include "cpu_consts.svh"

package isa_pkg;

    typedef logic [`WORD_SIZE-1:0] word_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ADI   = 4'd4,
        ORI   = 4'd5,
        LHI   = 4'd6,
        LWD   = 4'd7,
        SWD   = 4'd8,
        RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        ADD = 6'd0,
        SUB = 6'd1,
        AND = 6'd2,
        ORR = 6'd3,
        NOT = 6'd4,
        TCP = 6'd5,
        SHL = 6'd6,
        SHR = 6'd7,
        WWD = `FUNC_WWD,
        HLT = `FUNC_HLT
    } func_e;

    // field extraction from an instruction word
    function automatic opcode_e inst_opcode(word_t inst);
        return opcode_e'(inst[15:12]);
    endfunction

    function automatic reg_idx_t inst_rs(word_t inst);
        return inst[11:10];
    endfunction

    function automatic reg_idx_t inst_rt(word_t inst);
        return inst[9:8];
    endfunction

    function automatic reg_idx_t inst_rd(word_t inst);
        return inst[7:6];
    endfunction

    function automatic func_e inst_func(word_t inst);
        return func_e'(inst[5:0]);
    endfunction

    function automatic word_t imm_sext(word_t inst);
        return {{(`WORD_SIZE-8){inst[7]}}, inst[7:0]};
    endfunction

    function automatic word_t imm_zext(word_t inst);
        return {{(`WORD_SIZE-8){1'b0}}, inst[7:0]};
    endfunction

endpackage

`default_nettype wire

/* hdl/pipe_pkg.sv */
`default_nettype none

`include "cpu_consts.svh"

package pipe_pkg;

    // holds 0 .. QUEUE_DEPTH inclusive
    typedef logic [$clog2(`QUEUE_DEPTH+1)-1:0] credit_t;

    // index plus wrap bit
    typedef logic [$clog2(`QUEUE_DEPTH):0] qptr_t;

    typedef enum logic [1:0] {
        RUN,
        MEM_WAIT,
        HALTED
    } exec_state_e;

endpackage

`default_nettype wire

/* hdl/fetch_unit.sv */
`default_nettype none

`include "cpu_consts.svh"

module fetch_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  credit_return,
    output logic       inst_read,
    output word_t      inst_addr,
    input  wire word_t inst_data,
    output logic       push_valid,
    output word_t      push_inst
);

    word_t   pc;
    credit_t credits;
    logic    started;  // low through reset so inst_read stays quiet
    logic    stopped;  // set once hlt has gone out
    logic    fire;
    logic    fetch_hlt;

    assign fire = started && !stopped && (credits != '0);

    // only enough decode to spot the halt
    assign fetch_hlt = (inst_opcode(inst_data) == RTYPE) && (inst_func(inst_data) == HLT);

    assign inst_read  = fire;
    assign inst_addr  = pc;
    assign push_valid = fire;
    assign push_inst  = inst_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= '0;
            credits <= credit_t'(`QUEUE_DEPTH);
            started <= 1'b0;
            stopped <= 1'b0;
        end else begin
            started <= 1'b1;
            if (fire) begin
                pc <= pc + 1'b1;
                if (fetch_hlt) begin
                    stopped <= 1'b1;
                end
            end
            case ({fire, credit_return})
                2'b10:   credits <= credits - 1'b1;  // spent on a push
                2'b01:   credits <= credits + 1'b1;  // came back from a pop
                default: credits <= credits;         // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/inst_queue.sv */
`default_nettype none

`include "cpu_consts.svh"

module inst_queue
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  push_valid,
    input  wire word_t push_inst,
    output logic       head_valid,
    output word_t      head_inst,
    input  wire logic  pop,
    output logic       credit_return
);

    localparam int IDX_W = $clog2(`QUEUE_DEPTH);

    word_t mem [`QUEUE_DEPTH];
    qptr_t wr_ptr;
    qptr_t rd_ptr;

    // equal pointers including wrap bit means empty
    assign head_valid = (wr_ptr != rd_ptr);
    assign head_inst  = mem[rd_ptr[IDX_W-1:0]];

    // the credit loop keeps pushes within depth
    always_ff @(posedge clk) begin
        if (push_valid) begin
            mem[wr_ptr[IDX_W-1:0]] <= push_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            credit_return <= pop;  // one credit back the cycle after a pop
        end
    end

endmodule

`default_nettype wire

/* hdl/exec_core.sv */
`default_nettype none

`include "cpu_consts.svh"

module exec_core
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  head_valid,
    input  wire word_t head_inst,
    output logic       pop,
    output logic       data_read,
    output logic       data_write,
    output word_t      data_addr,
    output word_t      data_wdata,
    input  wire word_t data_rdata,
    input  wire logic  data_ready,
    output word_t      num_inst,
    output word_t      output_port,
    output logic       output_valid,
    output logic       is_halted
);

    word_t       regs [`NUM_REGS];
    logic        dec_valid;
    word_t       dec_inst;
    exec_state_e state;

    opcode_e  opcode;
    func_e    func;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    word_t    rs_val;
    word_t    rt_val;
    logic     is_rtype;
    logic     is_lwd;
    logic     is_swd;
    logic     is_wwd;
    logic     is_hlt;
    logic     active;
    logic     mem_req;
    logic     commit;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    alu_result;
    word_t    wb_data;

    assign opcode = inst_opcode(dec_inst);
    assign func   = inst_func(dec_inst);
    assign rs     = inst_rs(dec_inst);
    assign rt     = inst_rt(dec_inst);
    assign rd     = inst_rd(dec_inst);
    assign rs_val = regs[rs];
    assign rt_val = regs[rt];

    assign is_rtype = (opcode == RTYPE);
    assign is_lwd   = (opcode == LWD);
    assign is_swd   = (opcode == SWD);
    assign is_wwd   = is_rtype && (func == WWD);
    assign is_hlt   = is_rtype && (func == HLT);

    assign active  = dec_valid && (state != HALTED);
    assign mem_req = active && (is_lwd || is_swd);
    assign commit  = active && (!(is_lwd || is_swd) || data_ready);  // mem ops wait for ready

    // refill decode when empty or draining this cycle
    assign pop = head_valid && (state != HALTED) && (!dec_valid || commit);

    assign data_read  = mem_req && is_lwd;
    assign data_write = mem_req && is_swd;
    assign data_addr  = rs_val + imm_sext(dec_inst);
    assign data_wdata = rt_val;

    assign is_halted = (state == HALTED);

    always_comb begin
        alu_result = '0;
        wr_en      = 1'b0;
        wr_idx     = rt;  // immediate formats write rt
        case (opcode)
            ADI: begin
                alu_result = rs_val + imm_sext(dec_inst);
                wr_en      = 1'b1;
            end
            ORI: begin
                alu_result = rs_val | imm_zext(dec_inst);
                wr_en      = 1'b1;
            end
            LHI: begin
                alu_result = {dec_inst[7:0], 8'h00};
                wr_en      = 1'b1;
            end
            LWD: begin
                wr_en = 1'b1;  // data comes from memory
            end
            RTYPE: begin
                wr_idx = rd;
                wr_en  = 1'b1;
                case (func)
                    ADD:     alu_result = rs_val + rt_val;
                    SUB:     alu_result = rs_val - rt_val;
                    AND:     alu_result = rs_val & rt_val;
                    ORR:     alu_result = rs_val | rt_val;
                    NOT:     alu_result = ~rs_val;
                    TCP:     alu_result = ~rs_val + 1'b1;
                    SHL:     alu_result = {rs_val[`WORD_SIZE-2:0], 1'b0};
                    SHR:     alu_result = {rs_val[`WORD_SIZE-1], rs_val[`WORD_SIZE-1:1]};
                    default: wr_en = 1'b0;  // wwd, hlt
                endcase
            end
            default: wr_en = 1'b0;  // swd and unused opcodes
        endcase
    end

    assign wb_data = is_lwd ? data_rdata : alu_result;

    always_ff @(posedge clk) begin
        if (pop) begin
            dec_inst <= head_inst;
        end
        if (commit && wr_en) begin
            regs[wr_idx] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= RUN;
            dec_valid    <= 1'b0;
            num_inst     <= '0;
            output_port  <= '0;
            output_valid <= 1'b0;
        end else begin
            output_valid <= commit && is_wwd;
            if (pop) begin
                dec_valid <= 1'b1;
            end else if (commit) begin
                dec_valid <= 1'b0;
            end
            if (commit) begin
                num_inst <= num_inst + 1'b1;
            end
            if (commit && is_wwd) begin
                output_port <= rs_val;
            end
            case (state)
                RUN: begin
                    if (commit && is_hlt) begin
                        state <= HALTED;
                    end else if (mem_req && !data_ready) begin
                        state <= MEM_WAIT;
                    end
                end
                MEM_WAIT: begin
                    if (data_ready) begin
                        state <= RUN;
                    end
                end
                default: state <= HALTED;  // held until reset
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/tsc_cpu.sv */
`default_nettype none

module tsc_cpu
    import isa_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    output wire logic  inst_read,
    output wire word_t inst_addr,
    input  wire word_t inst_data,
    output wire logic  data_read,
    output wire logic  data_write,
    output wire word_t data_addr,
    output wire word_t data_wdata,
    input  wire word_t data_rdata,
    input  wire logic  data_ready,
    output wire word_t num_inst,
    output wire word_t output_port,
    output wire logic  output_valid,
    output wire logic  is_halted
);

    wire logic  push_valid;
    wire word_t push_inst;
    wire logic  credit_return;
    wire logic  head_valid;
    wire word_t head_inst;
    wire logic  pop;

    fetch_unit i_fetch_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .credit_return (credit_return),
        .inst_read     (inst_read),
        .inst_addr     (inst_addr),
        .inst_data     (inst_data),
        .push_valid    (push_valid),
        .push_inst     (push_inst)
    );

    inst_queue i_inst_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .push_valid    (push_valid),
        .push_inst     (push_inst),
        .head_valid    (head_valid),
        .head_inst     (head_inst),
        .pop           (pop),
        .credit_return (credit_return)
    );

    exec_core i_exec_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_valid   (head_valid),
        .head_inst    (head_inst),
        .pop          (pop),
        .data_read    (data_read),
        .data_write   (data_write),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .data_ready   (data_ready),
        .num_inst     (num_inst),
        .output_port  (output_port),
        .output_valid (output_valid),
        .is_halted    (is_halted)
    );

endmodule

`default_nettype wire

/* verification/tb_tsc_cpu.sv */
`default_nettype none

`include "cpu_consts.svh"

module tb_tsc_cpu
    import isa_pkg::*;
    import pipe_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int TOTAL_INSTS  = 100;  // upper bound over all programs
    localparam int WORST_CPI    = 35;   // forced 30 cycle stall plus pipeline
    localparam int NUM_TESTS    = 5;

    logic  clk, rst_n, inst_read, data_read, data_write, data_ready, output_valid, is_halted;
    word_t inst_addr, inst_data, data_addr, data_wdata, data_rdata, num_inst, output_port;
    word_t imem [256];
    word_t dmem [256];
    word_t model_mem [256];
    word_t got_q [$];
    word_t exp_q [$];
    int    exp_count, errors, checks, stall_low, forced_stall, ready_delay;
    logic  ready_busy;
    word_t max_read_addr;
    int unsigned lcg_state = 98816;

    tsc_cpu i_tsc_cpu (.*);

    assign inst_data  = imem[inst_addr[7:0]];
    assign data_rdata = dmem[data_addr[7:0]];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'h7fff;
    endfunction

    function automatic word_t rtype_word(func_e f, int rs, int rt, int rd);
        return {4'hF, 2'(rs), 2'(rt), 2'(rd), 6'(f)};
    endfunction

    function automatic word_t imm_word(opcode_e op, int rs, int rt, int imm);
        return {4'(op), 2'(rs), 2'(rt), 8'(imm)};
    endfunction

    // architectural model that fills exp_q, exp_count and model_mem
    function automatic void predict_results(input word_t prog[$]);
        word_t r [`NUM_REGS];
        word_t w, a, b, imm_s, addr;
        exp_q.delete();
        exp_count = 0;
        foreach (r[i]) r[i] = '0;
        for (int pc = 0; pc < prog.size(); pc++) begin
            w = prog[pc];
            a = r[w[11:10]];
            b = r[w[9:8]];
            imm_s = {{8{w[7]}}, w[7:0]};
            addr = a + imm_s;
            exp_count++;
            case (opcode_e'(w[15:12]))
                ADI: r[w[9:8]] = a + imm_s;
                ORI: r[w[9:8]] = a | {8'h00, w[7:0]};
                LHI: r[w[9:8]] = {w[7:0], 8'h00};
                LWD: r[w[9:8]] = model_mem[addr[7:0]];
                SWD: model_mem[addr[7:0]] = b;
                RTYPE: begin
                    case (func_e'(w[5:0]))
                        ADD: r[w[7:6]] = a + b;
                        SUB: r[w[7:6]] = a - b;
                        AND: r[w[7:6]] = a & b;
                        ORR: r[w[7:6]] = a | b;
                        NOT: r[w[7:6]] = ~a;
                        TCP: r[w[7:6]] = 16'd0 - a;
                        SHL: r[w[7:6]] = a << 1;
                        SHR: r[w[7:6]] = word_t'($signed(a) >>> 1);
                        WWD: exp_q.push_back(a);
                        HLT: return;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // ready comes 0..3 cycles after a request, or after forced_stall cycles once
    always @(negedge clk) begin
        if (!rst_n || !(data_read || data_write) || data_ready) begin
            data_ready = 1'b0;
            ready_busy = 1'b0;
        end else begin
            if (!ready_busy) begin
                ready_busy   = 1'b1;
                ready_delay  = (forced_stall > 0) ? forced_stall : int'(next_rand() % 4);
                forced_stall = 0;
            end
            if (ready_delay == 0) data_ready = 1'b1;
            else ready_delay--;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (data_write && data_ready) dmem[data_addr[7:0]] <= data_wdata;
            if (output_valid) got_q.push_back(output_port);
            if (inst_read && inst_addr > max_read_addr) max_read_addr = inst_addr;
            if (data_write && !data_ready && !inst_read) stall_low++;
        end
    end

    task automatic run_program(input string name, input word_t prog[$]);
        int limit;
        for (int a = 0; a < 256; a++) begin
            imem[a] = 16'hA000 | word_t'((a * 37) & 16'h0fff);  // unused opcode
            dmem[a] = word_t'(a * 16'h0101) ^ 16'h3c5a;
            model_mem[a] = dmem[a];
        end
        foreach (prog[i]) imem[i] = prog[i];
        predict_results(prog);
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        check_bit({name, " inst_read in reset"}, inst_read, 1'b0);
        check_bit({name, " data_read in reset"}, data_read, 1'b0);
        check_bit({name, " data_write in reset"}, data_write, 1'b0);
        check_bit({name, " output_valid in reset"}, output_valid, 1'b0);
        check_bit({name, " is_halted in reset"}, is_halted, 1'b0);
        check_word({name, " num_inst in reset"}, num_inst, '0);
        check_word({name, " output_port in reset"}, output_port, '0);
        got_q.delete();
        max_read_addr = '0;
        stall_low = 0;
        rst_n = 1'b1;
        limit = prog.size() * WORST_CPI + 20;
        while (!is_halted && limit > 0) begin
            @(negedge clk);
            limit--;
        end
        if (!is_halted) begin
            errors++;
            $display("%s: DUT did not halt within the expected number of cycles", name);
        end
        check_word({name, " num_inst"}, num_inst, word_t'(exp_count));
        check_word({name, " output count"}, word_t'(got_q.size()), word_t'(exp_q.size()));
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++)
            check_word($sformatf("%s output_port[%0d]", name, i), got_q[i], exp_q[i]);
        check_bit({name, " no fetch past hlt"}, max_read_addr <= word_t'(exp_count - 1), 1'b1);
        for (int a = 0; a < 256; a++)
            check_word($sformatf("%s dmem[%0d]", name, a), dmem[a], model_mem[a]);
    endtask

    task automatic alu_test();
        word_t prog [$];
        prog = '{imm_word(LHI, 0, 0, 8'h12), imm_word(ORI, 0, 0, 8'h34),
                 imm_word(LHI, 0, 1, 8'hF0), imm_word(ORI, 1, 1, 8'h0F)};
        for (int f = 0; f < 8; f++) begin
            prog.push_back(rtype_word(func_e'(f), f % 2, 1 - f % 2, 2));  // odd ops on r1
            prog.push_back(rtype_word(WWD, 2, 0, 0));
        end
        prog.push_back(rtype_word(HLT, 0, 0, 0));
        run_program("alu", prog);
    endtask

    task automatic imm_test();
        word_t prog [$];
        prog = '{imm_word(LHI, 0, 0, 0), imm_word(ORI, 0, 0, 8'h10),
                 imm_word(ADI, 0, 1, -5), rtype_word(WWD, 1, 0, 0),
                 imm_word(ADI, 1, 2, 100), rtype_word(WWD, 2, 0, 0),
                 imm_word(ORI, 0, 3, 8'h85), rtype_word(WWD, 3, 0, 0),
                 imm_word(LHI, 0, 3, 8'h80), rtype_word(WWD, 3, 0, 0),
                 rtype_word(HLT, 0, 0, 0)};
        run_program("imm", prog);
    endtask

    task automatic mem_test();
        word_t prog [$];
        prog = '{imm_word(LHI, 0, 0, 0), imm_word(ORI, 0, 0, 8'h20),
                 imm_word(LHI, 0, 1, 8'hAB), imm_word(ORI, 1, 1, 8'hCD),
                 imm_word(LHI, 0, 2, 8'h5A), imm_word(ADI, 0, 3, -3),
                 imm_word(SWD, 0, 1, 1), imm_word(SWD, 0, 2, 2), imm_word(SWD, 3, 3, 8),
                 imm_word(LWD, 0, 2, 1), imm_word(LWD, 0, 1, 2), imm_word(LWD, 3, 0, 8),
                 imm_word(LWD, 3, 3, 8'h7F),  // untouched word
                 rtype_word(WWD, 0, 0, 0), rtype_word(WWD, 1, 0, 0),
                 rtype_word(WWD, 2, 0, 0), rtype_word(WWD, 3, 0, 0),
                 rtype_word(HLT, 0, 0, 0)};
        run_program("mem", prog);
    endtask

    task automatic halt_test();
        word_t prog [$];
        prog = '{imm_word(LHI, 0, 0, 8'h77), rtype_word(WWD, 0, 0, 0),
                 rtype_word(HLT, 0, 0, 0), imm_word(ADI, 0, 0, 1),
                 rtype_word(WWD, 0, 0, 0), rtype_word(WWD, 0, 0, 0)};
        run_program("halt", prog);
        repeat (5) @(negedge clk);
        check_bit("halt is_halted held", is_halted, 1'b1);
        check_word("halt num_inst held", num_inst, word_t'(exp_count));
        check_bit("halt no fetch after halt", max_read_addr <= word_t'(exp_count - 1), 1'b1);
    endtask

    task automatic backpressure_test();
        word_t prog [$];
        prog = '{imm_word(LHI, 0, 0, 0), imm_word(ORI, 0, 0, 8'h40),
                 imm_word(LHI, 0, 1, 8'h11), imm_word(SWD, 0, 1, 0)};
        for (int k = 0; k < 10; k++) begin
            prog.push_back(rtype_word(WWD, 1, 0, 0));
            prog.push_back(imm_word(ADI, 1, 1, 1));
        end
        prog.push_back(rtype_word(HLT, 0, 0, 0));
        forced_stall = 30;
        run_program("backpressure", prog);
        check_bit("backpressure inst_read low in stall", stall_low >= 20, 1'b1);
    endtask

    initial begin
        rst_n = 1'b0;
        data_ready = 1'b0;
        ready_busy = 1'b0;
        ready_delay = 0;
        forced_stall = 0;
        errors = 0;
        checks = 0;
        alu_test();
        imm_test();
        mem_test();
        halt_test();
        backpressure_test();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #((TOTAL_INSTS * WORST_CPI + NUM_TESTS * (RESET_CYCLES + 10)) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* tsc_cpu.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_unit.sv
hdl/inst_queue.sv
hdl/exec_core.sv
hdl/tsc_cpu.sv
verification/tb_tsc_cpu.sv

/* run_sim.sh */
#!/bin/sh
# builds the tsc_cpu testbench with verilator, runs it, and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing -Wno-fatal -f tsc_cpu.f --top-module tb_tsc_cpu -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_tsc_cpu > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi
cat "$LOG"

if grep -q "All tests passed!" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
